/* Makefile */
# Verilator flow for the APB AES-128 peripheral

VERILATOR ?= verilator
TOP       ?= aes_tb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

sim: build
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "test failed" $(LOG); then echo "Simulation FAILED, see $(LOG)"; exit 1; fi
	@if ! grep -q "test passed" $(LOG); then echo "Simulation ended early, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* sim.f */
src/aes_pkg.sv
src/aes_regs_pkg.sv
src/aes_apb_regs.sv
src/aes_ctrl_fsm.sv
src/aes_round_counter.sv
src/aes_datapath.sv
src/aes_apb_top.sv
tests/aes_tb.sv

/* src/aes_apb_regs.sv */
/*
  APB register bank of the AES peripheral.
  Holds the key, collects four data-in words into a block for the core and
  hands the ciphertext back one word per data-out read.
*/
`timescale 1ns/1ns

module aes_apb_regs
  import aes_pkg::*, aes_regs_pkg::*;
(
  input  logic      clk,
  input  logic      reset_n,
  input  logic      psel,
  input  logic      penable,
  input  logic      pwrite,
  input  apb_addr_t paddr,
  input  apb_data_t pwdata,
  input  logic      take_in,
  input  logic      load_out,
  input  logic      busy,
  input  block_t    block_out,
  output apb_data_t prdata,
  output logic      pready,
  output logic      pslverr,
  output logic      in_full,
  output logic      out_full,
  output block_t    block_in,
  output key_t      key
);

  logic [2:0] ofs;
  logic       aligned;
  logic       din_access;
  logic       dout_access;
  logic       wr_en;
  logic       rd_en;
  logic       bad_read;
  logic       bad_write;
  logic [1:0] in_cnt;
  logic [1:0] out_cnt;
  block_t     out_buf;

  assign ofs     = paddr[4:2];
  assign aligned = (paddr[1:0] == 2'b00);

  assign din_access  = psel & aligned & pwrite & (ofs == DIN_OFS);
  assign dout_access = psel & aligned & ~pwrite & (ofs == DOUT_OFS);

  // Stall only on a full input block or an empty output buffer
  assign pready = ~(din_access & in_full & ~take_in) & ~(dout_access & ~out_full);

  assign bad_read  = ~pwrite & (ofs != STATUS_OFS) & (ofs != DOUT_OFS);
  assign bad_write = pwrite & (ofs >= STATUS_OFS) & (ofs != DIN_OFS);
  assign pslverr   = psel & penable & (~aligned | bad_read | bad_write);

  // Completed transfers, misaligned ones change nothing
  assign wr_en = psel & penable & pready & aligned & pwrite;
  assign rd_en = psel & penable & pready & aligned & ~pwrite;

  always_comb begin
    prdata = '0;
    if (ofs == STATUS_OFS) begin
      prdata[STATUS_OUT_FULL_BIT] = out_full;
      prdata[STATUS_BUSY_BIT]     = busy;
    end else if (ofs == DOUT_OFS) begin
      prdata = out_buf[31:0];
    end
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      key <= '0;
    end else if (wr_en) begin
      case (ofs)
        KEY0_OFS: key[31:0]   <= pwdata;
        KEY1_OFS: key[63:32]  <= pwdata;
        KEY2_OFS: key[95:64]  <= pwdata;
        KEY3_OFS: key[127:96] <= pwdata;
        default:  key         <= key;
      endcase
    end
  end

  // First write ends up in bits 31:0 after four shifts
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      block_in <= '0;
      in_cnt   <= 2'd0;
      in_full  <= 1'b0;
    end else begin
      if (take_in) begin
        in_full <= 1'b0;
      end
      if (wr_en && ofs == DIN_OFS) begin
        block_in <= {pwdata, block_in[127:32]};
        in_cnt   <= in_cnt + 2'd1;
        if (in_cnt == 2'(WORDS_PER_BLOCK - 1)) begin
          in_full <= 1'b1;
        end
      end
    end
  end

  // Output buffer, low word is read first
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      out_buf  <= '0;
      out_cnt  <= 2'd0;
      out_full <= 1'b0;
    end else if (load_out) begin
      out_buf  <= block_out;
      out_cnt  <= 2'd0;
      out_full <= 1'b1;
    end else if (rd_en && ofs == DOUT_OFS) begin
      out_buf <= {32'd0, out_buf[127:32]};
      out_cnt <= out_cnt + 2'd1;
      if (out_cnt == 2'(WORDS_PER_BLOCK - 1)) begin
        out_full <= 1'b0;
      end
    end
  end

endmodule

/* src/aes_apb_top.sv */
/*
  APB AES-128 encryption peripheral.
  Key at offsets 0 to 3, status at 4, data in at 5 and data out at 6.
*/
`timescale 1ns/1ns

module aes_apb_top
  import aes_pkg::*, aes_regs_pkg::*;
(
  input  logic      clk,
  input  logic      reset_n,
  input  logic      psel,
  input  logic      penable,
  input  logic      pwrite,
  input  apb_addr_t paddr,
  input  apb_data_t pwdata,
  output apb_data_t prdata,
  output logic      pready,
  output logic      pslverr
);

  logic   in_full;
  logic   out_full;
  logic   take_in;
  logic   load_out;
  logic   start;
  logic   busy;
  logic   last_round;
  round_t round;
  block_t block_in;
  block_t block_out;
  key_t   key;

  aes_apb_regs aes_apb_regs_inst (
    .clk       (clk),
    .reset_n   (reset_n),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .paddr     (paddr),
    .pwdata    (pwdata),
    .take_in   (take_in),
    .load_out  (load_out),
    .busy      (busy),
    .block_out (block_out),
    .prdata    (prdata),
    .pready    (pready),
    .pslverr   (pslverr),
    .in_full   (in_full),
    .out_full  (out_full),
    .block_in  (block_in),
    .key       (key)
  );

  aes_ctrl_fsm aes_ctrl_fsm_inst (
    .clk        (clk),
    .reset_n    (reset_n),
    .in_full    (in_full),
    .out_full   (out_full),
    .last_round (last_round),
    .start      (start),
    .take_in    (take_in),
    .load_out   (load_out),
    .busy       (busy)
  );

  aes_round_counter aes_round_counter_inst (
    .clk        (clk),
    .reset_n    (reset_n),
    .start      (start),
    .round      (round),
    .last_round (last_round)
  );

  aes_datapath aes_datapath_inst (
    .clk       (clk),
    .reset_n   (reset_n),
    .start     (start),
    .round     (round),
    .block_in  (block_in),
    .key       (key),
    .block_out (block_out)
  );

endmodule

/* src/aes_ctrl_fsm.sv */
/*
  Control FSM of the AES peripheral.
  Starts the core when a block is buffered and moves the result into the
  output buffer once there is room for it.
*/
`timescale 1ns/1ns

module aes_ctrl_fsm (
  input  logic clk,
  input  logic reset_n,
  input  logic in_full,
  input  logic out_full,
  input  logic last_round,
  output logic start,
  output logic take_in,
  output logic load_out,
  output logic busy
);

  typedef enum logic [1:0] {
    st_idle,
    st_run,
    st_hold
  } state_t;

  state_t state, state_nxt;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      state <= st_idle;
    end else begin
      state <= state_nxt;
    end
  end

  always_comb begin
    state_nxt = state;
    start     = 1'b0;
    load_out  = 1'b0;
    case (state)
      st_idle: begin
        if (in_full) begin
          start     = 1'b1;
          state_nxt = st_run;
        end
      end
      st_run: begin
        if (last_round) begin
          state_nxt = st_hold;
        end
      end
      // Result is final, wait until the host has drained the last one
      st_hold: begin
        if (!out_full) begin
          load_out = 1'b1;
          if (in_full) begin
            start     = 1'b1;
            state_nxt = st_run;
          end else begin
            state_nxt = st_idle;
          end
        end
      end
      default: state_nxt = st_idle;
    endcase
  end

  // Input buffer is free again as soon as the core has taken the block
  assign take_in = start;
  assign busy    = (state != st_idle);

endmodule

/* src/aes_datapath.sv */
/*
  Iterative AES-128 encryption datapath.
  One round and one key expansion step per clock; the state register holds
  the ciphertext after round 10 until the next start.
*/
`timescale 1ns/1ns

module aes_datapath
  import aes_pkg::*;
(
  input  logic   clk,
  input  logic   reset_n,
  input  logic   start,
  input  round_t round,
  input  block_t block_in,
  input  key_t   key,
  output block_t block_out
);

  block_t state;
  key_t   round_key;
  key_t   round_key_nxt;
  block_t shifted;
  block_t mixed;
  block_t state_nxt;

  // Key for the current round, derived from the previous one
  assign round_key_nxt = key_step(round_key, rcon(round));

  assign shifted = shift_rows(sub_bytes(state));

  // Final round has no MixColumns
  assign mixed = (round == NUM_ROUNDS) ? shifted : mix_columns(shifted);

  assign state_nxt = mixed ^ round_key_nxt;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      state     <= '0;
      round_key <= '0;
    end else if (start) begin
      // Initial AddRoundKey
      state     <= block_in ^ key;
      round_key <= key;
    end else if (round != '0) begin
      state     <= state_nxt;
      round_key <= round_key_nxt;
    end
  end

  assign block_out = state;

endmodule

/* src/aes_pkg.sv */
/*
  AES-128 cipher definitions shared by the encryption datapath.
  Holds the block, key and round types, the round count, the S-box table
  and the round transformation functions used for one round per clock.
*/
package aes_pkg;

  typedef logic [127:0] block_t;
  typedef logic [127:0] key_t;
  typedef logic [3:0]   round_t;

  localparam round_t NUM_ROUNDS = 4'd10;

  // Forward S-box, entry 0 in the most significant byte
  localparam logic [0:255][7:0] SBOX = {
    128'h637c777bf26b6fc53001672bfed7ab76, 128'hca82c97dfa5947f0add4a2af9ca472c0,
    128'hb7fd9326363ff7cc34a5e5f171d83115, 128'h04c723c31896059a071280e2eb27b275,
    128'h09832c1a1b6e5aa0523bd6b329e32f84, 128'h53d100ed20fcb15b6acbbe394a4c58cf,
    128'hd0efaafb434d338545f9027f503c9fa8, 128'h51a3408f929d38f5bcb6da2110fff3d2,
    128'hcd0c13ec5f974417c4a77e3d645d1973, 128'h60814fdc222a908846eeb814de5e0bdb,
    128'he0323a0a4906245cc2d3ac629195e479, 128'he7c8376d8dd54ea96c56f4ea657aae08,
    128'hba78252e1ca6b4c6e8dd741f4bbd8b8a, 128'h703eb5664803f60e613557b986c11d9e,
    128'he1f8981169d98e949b1e87e9ce5528df, 128'h8ca1890dbfe6426841992d0fb054bb16
  };

  function automatic logic [7:0] xtime(input logic [7:0] b);
    return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
  endfunction

  function automatic block_t sub_bytes(input block_t s);
    block_t o;
    for (int i = 0; i < 16; i++) begin
      o[8*i +: 8] = SBOX[s[8*i +: 8]];
    end
    return o;
  endfunction

  // Byte n of the state sits at bits 127-8n, column c holds bytes 4c..4c+3
  function automatic block_t shift_rows(input block_t s);
    block_t o;
    for (int c = 0; c < 4; c++) begin
      for (int r = 0; r < 4; r++) begin
        o[127 - 8*(4*c + r) -: 8] = s[127 - 8*(4*((c + r) % 4) + r) -: 8];
      end
    end
    return o;
  endfunction

  function automatic block_t mix_columns(input block_t s);
    block_t o;
    logic [7:0] a0, a1, a2, a3;
    for (int c = 0; c < 4; c++) begin
      {a0, a1, a2, a3} = s[127 - 32*c -: 32];
      o[127 - 32*c -: 32] = {xtime(a0) ^ xtime(a1) ^ a1 ^ a2 ^ a3,
                             a0 ^ xtime(a1) ^ xtime(a2) ^ a2 ^ a3,
                             a0 ^ a1 ^ xtime(a2) ^ xtime(a3) ^ a3,
                             xtime(a0) ^ a0 ^ a1 ^ a2 ^ xtime(a3)};
    end
    return o;
  endfunction

  function automatic logic [7:0] rcon(input round_t r);
    case (r)
      4'd1:    return 8'h01;
      4'd2:    return 8'h02;
      4'd3:    return 8'h04;
      4'd4:    return 8'h08;
      4'd5:    return 8'h10;
      4'd6:    return 8'h20;
      4'd7:    return 8'h40;
      4'd8:    return 8'h80;
      4'd9:    return 8'h1b;
      4'd10:   return 8'h36;
      default: return 8'h00;
    endcase
  endfunction

  // One key expansion step, word 0 of the key in the top 32 bits
  function automatic key_t key_step(input key_t k, input logic [7:0] rc);
    logic [31:0] rot, temp, n0, n1, n2, n3;
    rot  = {k[23:0], k[31:24]};
    temp = {SBOX[rot[31:24]] ^ rc, SBOX[rot[23:16]], SBOX[rot[15:8]], SBOX[rot[7:0]]};
    n0   = k[127:96] ^ temp;
    n1   = k[95:64] ^ n0;
    n2   = k[63:32] ^ n1;
    n3   = k[31:0] ^ n2;
    return {n0, n1, n2, n3};
  endfunction

endpackage

/* src/aes_regs_pkg.sv */
/*
  Register map of the APB AES peripheral.
  Word offsets are the byte address divided by four.
*/
package aes_regs_pkg;

  typedef logic [4:0]  apb_addr_t;
  typedef logic [31:0] apb_data_t;

  // Key words, offset i fills key bits 32i+31 down to 32i
  localparam logic [2:0] KEY0_OFS   = 3'd0;
  localparam logic [2:0] KEY1_OFS   = 3'd1;
  localparam logic [2:0] KEY2_OFS   = 3'd2;
  localparam logic [2:0] KEY3_OFS   = 3'd3;
  localparam logic [2:0] STATUS_OFS = 3'd4;
  localparam logic [2:0] DIN_OFS    = 3'd5;
  localparam logic [2:0] DOUT_OFS   = 3'd6;

  // Status word bits
  localparam int STATUS_OUT_FULL_BIT = 0;
  localparam int STATUS_BUSY_BIT     = 1;

  localparam int WORDS_PER_BLOCK = 4;

endpackage

/* src/aes_round_counter.sv */
/*
  Round counter of the AES core.
  Counts rounds 1 to 10 after start and flags the final round.
*/
`timescale 1ns/1ns

module aes_round_counter
  import aes_pkg::*;
(
  input  logic   clk,
  input  logic   reset_n,
  input  logic   start,
  output round_t round,
  output logic   last_round
);

  logic stepped;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      round   <= '0;
      stepped <= 1'b0;
    end else begin
      stepped <= 1'b0;
      if (start) begin
        round   <= 4'd1;
        stepped <= 1'b1;
      end else if (round == NUM_ROUNDS) begin
        round <= '0;
      end else if (round != '0) begin
        round   <= round + 4'd1;
        stepped <= 1'b1;
      end
    end
  end

  assign last_round = (round == NUM_ROUNDS) & stepped;

endmodule

/* tests/aes_tb.sv */
/*
  Testbench for the APB AES-128 encryption peripheral.
  Drives key and plaintext words over APB and reads back the ciphertext.
  Results are checked against a reference model with its own S-box.
*/
`timescale 1ns/1ns

module aes_tb
  import aes_pkg::*, aes_regs_pkg::*;
;

  localparam int READY_TIMEOUT = 100;
  localparam int POLL_LIMIT    = 50;
  localparam int NUM_RANDOM    = 20;
  localparam int BLOCK_LATENCY = 13;

  logic      clk;
  logic      reset_n;
  logic      psel;
  logic      penable;
  logic      pwrite;
  apb_addr_t paddr;
  apb_data_t pwdata;
  apb_data_t prdata;
  logic      pready;
  logic      pslverr;

  logic [7:0] sbox_tab [0:255];
  block_t     exp_q[$];
  block_t     got_q[$];
  block_t     cmp_got;
  block_t     cmp_exp;
  int         compared;
  int         expected_total;
  int         seed;

  aes_apb_top aes_apb_top_inst (
    .clk     (clk),
    .reset_n (reset_n),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr)
  );

  always #10 clk = ~clk;

  function automatic logic [7:0] gf_mul(input logic [7:0] a, input logic [7:0] b);
    logic [7:0] p;
    logic [7:0] x;
    p = 8'h00;
    x = a;
    for (int i = 0; i < 8; i++) begin
      if (b[i]) begin
        p = p ^ x;
      end
      x = {x[6:0], 1'b0} ^ (x[7] ? 8'h1b : 8'h00);
    end
    return p;
  endfunction

  // S-box from the multiplicative inverse and the affine transform
  task automatic build_sbox();
    logic [7:0] inv;
    for (int a = 0; a < 256; a++) begin
      inv = 8'h00;
      for (int b = 1; b < 256; b++) begin
        if (gf_mul(8'(a), 8'(b)) == 8'h01) begin
          inv = 8'(b);
        end
      end
      sbox_tab[a] = inv ^ {inv[6:0], inv[7]} ^ {inv[5:0], inv[7:6]}
                  ^ {inv[4:0], inv[7:5]} ^ {inv[3:0], inv[7:4]} ^ 8'h63;
    end
  endtask

  function automatic block_t aes_encrypt_ref(input key_t k, input block_t pt);
    logic [7:0]  s [0:15];
    logic [7:0]  t [0:15];
    logic [31:0] w [0:43];
    logic [31:0] tmp;
    logic [7:0]  rc;
    logic [7:0]  a0, a1, a2, a3;
    block_t      ct;
    rc = 8'h01;
    for (int i = 0; i < 4; i++) begin
      w[i] = k[127 - 32*i -: 32];
    end
    // Full key schedule up front
    for (int i = 4; i < 44; i++) begin
      tmp = w[i-1];
      if (i % 4 == 0) begin
        tmp = {sbox_tab[tmp[23:16]] ^ rc, sbox_tab[tmp[15:8]],
               sbox_tab[tmp[7:0]], sbox_tab[tmp[31:24]]};
        rc = gf_mul(rc, 8'h02);
      end
      w[i] = w[i-4] ^ tmp;
    end
    for (int n = 0; n < 16; n++) begin
      s[n] = pt[127 - 8*n -: 8] ^ w[n/4][31 - 8*(n%4) -: 8];
    end
    for (int r = 1; r <= 10; r++) begin
      for (int n = 0; n < 16; n++) begin
        t[n] = sbox_tab[s[n]];
      end
      // Row of column c comes from column c+row
      for (int c = 0; c < 4; c++) begin
        for (int row = 0; row < 4; row++) begin
          s[4*c + row] = t[4*((c + row) % 4) + row];
        end
      end
      if (r < 10) begin
        for (int c = 0; c < 4; c++) begin
          a0 = s[4*c];
          a1 = s[4*c + 1];
          a2 = s[4*c + 2];
          a3 = s[4*c + 3];
          s[4*c]     = gf_mul(a0, 8'h02) ^ gf_mul(a1, 8'h03) ^ a2 ^ a3;
          s[4*c + 1] = a0 ^ gf_mul(a1, 8'h02) ^ gf_mul(a2, 8'h03) ^ a3;
          s[4*c + 2] = a0 ^ a1 ^ gf_mul(a2, 8'h02) ^ gf_mul(a3, 8'h03);
          s[4*c + 3] = gf_mul(a0, 8'h03) ^ a1 ^ a2 ^ gf_mul(a3, 8'h02);
        end
      end
      for (int n = 0; n < 16; n++) begin
        s[n] = s[n] ^ w[4*r + n/4][31 - 8*(n%4) -: 8];
      end
    end
    for (int n = 0; n < 16; n++) begin
      ct[127 - 8*n -: 8] = s[n];
    end
    return ct;
  endfunction

  task automatic stop_with_failure();
    $display("test failed");
    $fatal(1);
  endtask

  task automatic check_word(input apb_data_t got, input apb_data_t exp, input string what);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
      stop_with_failure();
    end
  endtask

  task automatic check_block(input block_t got, input block_t exp, input string what);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
      stop_with_failure();
    end
  endtask

  // One APB transfer, setup then access until pready
  task automatic apb_transfer(input logic write, input apb_addr_t addr,
                              input apb_data_t wdata, output apb_data_t rdata,
                              output logic err);
    int waited;
    waited  = 0;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = write;
    paddr   = addr;
    pwdata  = wdata;
    @(posedge clk);
    #2;
    penable = 1'b1;
    // pready is settled by mid-cycle
    @(negedge clk);
    while (!pready) begin
      waited++;
      if (waited >= READY_TIMEOUT) begin
        $display("ERROR at %0t ns: pready stayed low for %0d cycles at address %h",
                 $time, READY_TIMEOUT, addr);
        stop_with_failure();
      end
      @(negedge clk);
    end
    rdata = prdata;
    err   = pslverr;
    @(posedge clk);
    #2;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_write(input apb_addr_t addr, input apb_data_t data, output logic err);
    apb_data_t ignored;
    apb_transfer(1'b1, addr, data, ignored, err);
  endtask

  task automatic apb_read(input apb_addr_t addr, output apb_data_t data, output logic err);
    apb_transfer(1'b0, addr, '0, data, err);
  endtask

  function automatic apb_addr_t word_addr(input logic [2:0] ofs);
    return {ofs, 2'b00};
  endfunction

  task automatic load_key(input key_t k);
    logic err;
    for (int i = 0; i < 4; i++) begin
      apb_write(word_addr(KEY0_OFS + 3'(i)), k[32*i +: 32], err);
      check_word(apb_data_t'(err), 32'd0, "pslverr on key write");
    end
  endtask

  task automatic send_block(input block_t pt, input block_t expected);
    logic err;
    exp_q.push_back(expected);
    expected_total++;
    for (int i = 0; i < WORDS_PER_BLOCK; i++) begin
      apb_write(word_addr(DIN_OFS), pt[32*i +: 32], err);
      check_word(apb_data_t'(err), 32'd0, "pslverr on data-in write");
    end
  endtask

  task automatic receive_block();
    logic      err;
    apb_data_t word;
    block_t    b;
    for (int i = 0; i < WORDS_PER_BLOCK; i++) begin
      apb_read(word_addr(DOUT_OFS), word, err);
      check_word(apb_data_t'(err), 32'd0, "pslverr on data-out read");
      b[32*i +: 32] = word;
    end
    got_q.push_back(b);
  endtask

  task automatic poll_out_full(output apb_data_t status);
    logic err;
    int   polls;
    polls = 0;
    apb_read(word_addr(STATUS_OFS), status, err);
    while (!status[STATUS_OUT_FULL_BIT]) begin
      polls++;
      if (polls >= POLL_LIMIT) begin
        $display("ERROR at %0t ns: output buffer never filled", $time);
        stop_with_failure();
      end
      apb_read(word_addr(STATUS_OFS), status, err);
    end
  endtask

  // Ciphertext comparison, one result per clock
  always @(posedge clk) begin
    if (got_q.size() > 0) begin
      if (exp_q.size() == 0) begin
        $display("ERROR at %0t ns: a ciphertext was read with no block outstanding", $time);
        stop_with_failure();
      end else begin
        cmp_got = got_q.pop_front();
        cmp_exp = exp_q.pop_front();
        check_block(cmp_got, cmp_exp, "ciphertext");
        compared++;
      end
    end
  end

  initial begin
    key_t      k;
    block_t    pt;
    block_t    pt_b;
    apb_data_t word;
    logic      err;
    int        waited;
    seed           = 15214;
    compared       = 0;
    expected_total = 0;
    clk            = 1'b0;
    reset_n        = 1'b0;
    psel           = 1'b0;
    penable        = 1'b0;
    pwrite         = 1'b0;
    paddr          = '0;
    pwdata         = '0;
    build_sbox();
    repeat (3) @(posedge clk);
    #2;
    reset_n = 1'b1;

    apb_read(word_addr(STATUS_OFS), word, err);
    check_word(word, 32'd0, "status after reset");

    // FIPS-197 appendix B vector
    k  = 128'h2b7e151628aed2a6abf7158809cf4f3c;
    pt = 128'h3243f6a8885a308d313198a2e0370734;
    check_block(aes_encrypt_ref(k, pt), 128'h3925841d02dc09fbdc118597196a0b32,
                "reference model on FIPS-197 vector");
    load_key(k);
    send_block(pt, 128'h3925841d02dc09fbdc118597196a0b32);
    poll_out_full(word);
    check_word(word, 32'd1 << STATUS_OUT_FULL_BIT, "status after block done");
    receive_block();

    repeat (NUM_RANDOM) begin
      k  = {$random(seed), $random(seed), $random(seed), $random(seed)};
      pt = {$random(seed), $random(seed), $random(seed), $random(seed)};
      load_key(k);
      send_block(pt, aes_encrypt_ref(k, pt));
      receive_block();
    end

    // Second block buffered while the first computes, results held back
    k    = {$random(seed), $random(seed), $random(seed), $random(seed)};
    pt   = {$random(seed), $random(seed), $random(seed), $random(seed)};
    pt_b = {$random(seed), $random(seed), $random(seed), $random(seed)};
    load_key(k);
    send_block(pt, aes_encrypt_ref(k, pt));
    send_block(pt_b, aes_encrypt_ref(k, pt_b));
    // Both blocks are through the rounds by now, the second one waits in hold
    repeat (2 * BLOCK_LATENCY) @(posedge clk);
    #2;
    apb_read(word_addr(STATUS_OFS), word, err);
    check_word(word, (32'd1 << STATUS_OUT_FULL_BIT) | (32'd1 << STATUS_BUSY_BIT),
               "status while second result is held");
    receive_block();
    receive_block();

    // Bad accesses, then an encryption with the key left as is
    apb_write({DIN_OFS, 2'b01}, 32'hdeadbeef, err);
    check_word(apb_data_t'(err), 32'd1, "pslverr on misaligned data-in write");
    apb_write({KEY0_OFS, 2'b11}, 32'hcafef00d, err);
    check_word(apb_data_t'(err), 32'd1, "pslverr on misaligned key write");
    apb_read({DOUT_OFS, 2'b10}, word, err);
    check_word(apb_data_t'(err), 32'd1, "pslverr on misaligned data-out read");
    apb_read(word_addr(KEY1_OFS), word, err);
    check_word(apb_data_t'(err), 32'd1, "pslverr on key read");
    apb_write(word_addr(3'd7), 32'h12345678, err);
    check_word(apb_data_t'(err), 32'd1, "pslverr on write to offset 7");
    pt = {$random(seed), $random(seed), $random(seed), $random(seed)};
    send_block(pt, aes_encrypt_ref(k, pt));
    receive_block();

    waited = 0;
    while (got_q.size() != 0 && waited < 10) begin
      @(posedge clk);
      waited++;
    end
    if (compared == expected_total && got_q.size() == 0 && exp_q.size() == 0) begin
      $display("test passed");
      $finish;
    end else begin
      $display("ERROR at %0t ns: only %0d of %0d ciphertexts were compared",
               $time, compared, expected_total);
      stop_with_failure();
    end
  end

endmodule
